/* tb.f */
common/simple_system_pkg.sv
common/bus_dev_if.sv
bus/system_bus.sv
verilog/ram_1p.sv
timer/timer.sv
verilog/sim_ctrl.sv
verilog/simple_system.sv
dv/tb_simple_system.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the simple_system testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_simple_system \
  -f tb.f -o Vtb_simple_system > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_simple_system > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$SIM_LOG"; then
  exit 0
fi
exit 1

/* dv/tb_simple_system.sv */
// Testbench for simple_system, driving the host port directly.
// Concurrent assertions compare host responses, the timer interrupt and the
// sim-control outputs with models kept here. The first error ends the run.
// Inputs change 10 ns after the rising edge. RAM words are written before read.
`timescale 1ns/1ns
`default_nettype none

module tb_simple_system;

  localparam int RamDepth    = 1024;
  localparam int RamIdxW     = $clog2(RamDepth);
  localparam int NrWords     = 16;
  localparam int SelW        = $clog2(NrWords);
  localparam int NrRaw       = 8;
  localparam int TimerGap    = 7;
  localparam int NrTxns      = 3 * NrWords + 2 * NrRaw + 11;
  localparam int ClkPeriod   = 100;
  localparam int WatchdogCyc = 4 + NrTxns * 4 + 100;

  logic                                    clk_i;
  logic                                    rst_n_i;
  logic                                    host_req_i;
  logic [simple_system_pkg::AddrWidth-1:0] host_addr_i;
  logic                                    host_we_i;
  logic [simple_system_pkg::BeWidth-1:0]   host_be_i;
  logic [simple_system_pkg::DataWidth-1:0] host_wdata_i;
  logic                                    host_gnt_o;
  logic                                    host_rvalid_o;
  logic [simple_system_pkg::DataWidth-1:0] host_rdata_o;
  logic                                    host_err_o;
  logic                                    timer_irq_o;
  logic                                    char_valid_o;
  logic [7:0]                              char_o;
  logic                                    halt_o;

  // What the DUT owes in the next cycle
  logic        nxt_rvalid;
  logic        nxt_err;
  logic        nxt_chk;
  logic [31:0] nxt_rdata;
  logic        nxt_char_valid;
  logic [7:0]  nxt_char;
  logic        nxt_halt;
  logic [63:0] cmp_next;

  logic        exp_rvalid_q;
  logic        exp_err_q;
  logic        exp_chk_q;
  logic [31:0] exp_rdata_q;
  logic        exp_char_valid_q;
  logic [7:0]  exp_char_q;
  logic        exp_halt_q;
  logic        exp_irq_q;
  logic [63:0] mtime_model;
  logic [63:0] cmp_model;

  logic [31:0]        lfsr_q = 32'h10028a0d;
  logic [31:0]        ram_model [RamDepth];
  logic [RamIdxW-1:0] idx_list [NrWords];

  simple_system #(
    .RamDepth (RamDepth)
  ) simple_system_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .timer_irq_o   (timer_irq_o),
    .char_valid_o  (char_valid_o),
    .char_o        (char_o),
    .halt_o        (halt_o)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Higher alias_sel values land past RamDepth words
  function automatic logic [31:0] ram_addr(input logic [RamIdxW-1:0] idx,
                                           input logic [1:0] alias_sel);
    return simple_system_pkg::RamBase + 32'(alias_sel) * 32'(RamDepth * 4) +
           32'(idx) * 32'd4;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED: %s got %h expected %h", sig, got, exp);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic drive(input logic [31:0] addr, input logic we, input logic [3:0] be,
                       input logic [31:0] wdata, input logic [31:0] exp_data,
                       input logic exp_err, input logic chk);
    @(posedge clk_i);
    #10;
    host_req_i     = 1'b1;
    host_addr_i    = addr;
    host_we_i      = we;
    host_be_i      = be;
    host_wdata_i   = wdata;
    nxt_rvalid     = 1'b1;
    nxt_rdata      = exp_data;
    nxt_err        = exp_err;
    nxt_chk        = chk;
    nxt_char_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #10;
      host_req_i     = 1'b0;
      nxt_rvalid     = 1'b0;
      nxt_chk        = 1'b0;
      nxt_char_valid = 1'b0;
    end
  endtask

  task automatic ram_write(input logic [RamIdxW-1:0] idx, input logic [1:0] alias_sel,
                           input logic [3:0] be, input logic [31:0] data);
    drive(ram_addr(idx, alias_sel), 1'b1, be, data, '0, 1'b0, 1'b1);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ram_model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic ram_read(input logic [RamIdxW-1:0] idx, input logic [1:0] alias_sel);
    drive(ram_addr(idx, alias_sel), 1'b0, 4'hF, '0, ram_model[idx], 1'b0, 1'b1);
  endtask

  // Expected responses and the timer model lag the stimulus by one cycle
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_rvalid_q     <= 1'b0;
      exp_err_q        <= 1'b0;
      exp_chk_q        <= 1'b0;
      exp_rdata_q      <= '0;
      exp_char_valid_q <= 1'b0;
      exp_char_q       <= '0;
      exp_halt_q       <= 1'b0;
      exp_irq_q        <= 1'b0;
      mtime_model      <= '0;
      cmp_model        <= '1;
    end else begin
      exp_rvalid_q     <= nxt_rvalid;
      exp_err_q        <= nxt_err;
      exp_chk_q        <= nxt_chk;
      exp_rdata_q      <= nxt_rdata;
      exp_char_valid_q <= nxt_char_valid;
      exp_char_q       <= nxt_char;
      exp_halt_q       <= nxt_halt;
      exp_irq_q        <= mtime_model >= cmp_model;
      mtime_model      <= mtime_model + 64'd1;
      cmp_model        <= cmp_next;
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(host_rvalid_o || timer_irq_o || char_valid_o || halt_o))
    else report_failure("An output was high while reset was asserted");

  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_gnt_o == host_req_i)
    else report_mismatch("host_gnt_o", $sampled(host_gnt_o), $sampled(host_req_i));

  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_o == exp_rvalid_q)
    else report_mismatch("host_rvalid_o", $sampled(host_rvalid_o), $sampled(exp_rvalid_q));

  a_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_rvalid_q |-> host_err_o == exp_err_q)
    else report_mismatch("host_err_o", $sampled(host_err_o), $sampled(exp_err_q));

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (exp_rvalid_q && exp_chk_q) |-> host_rdata_o == exp_rdata_q)
    else report_mismatch("host_rdata_o", $sampled(host_rdata_o), $sampled(exp_rdata_q));

  a_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    timer_irq_o == exp_irq_q)
    else report_mismatch("timer_irq_o", $sampled(timer_irq_o), $sampled(exp_irq_q));

  a_char_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    char_valid_o == exp_char_valid_q)
    else report_mismatch("char_valid_o", $sampled(char_valid_o),
                         $sampled(exp_char_valid_q));

  a_char: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    char_valid_o |-> char_o == exp_char_q)
    else report_mismatch("char_o", $sampled(char_o), $sampled(exp_char_q));

  a_halt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halt_o == exp_halt_q)
    else report_mismatch("halt_o", $sampled(halt_o), $sampled(exp_halt_q));

  initial begin : watchdog
    #(WatchdogCyc * ClkPeriod);
    $display("Timeout after %0d cycles before the tests finished", WatchdogCyc);
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin : stimulus
    logic [31:0]     data;
    logic [31:0]     first_lo;
    logic [31:0]     target;
    logic [SelW-1:0] sel;
    host_req_i     = 1'b0;
    host_addr_i    = '0;
    host_we_i      = 1'b0;
    host_be_i      = '0;
    host_wdata_i   = '0;
    nxt_rvalid     = 1'b0;
    nxt_err        = 1'b0;
    nxt_chk        = 1'b0;
    nxt_rdata      = '0;
    nxt_char_valid = 1'b0;
    nxt_char       = '0;
    nxt_halt       = 1'b0;
    cmp_next       = '1;
    rst_n_i        = 1'b0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;

    // Full words first so every word read later is defined
    for (int i = 0; i < NrWords; i++) begin
      idx_list[i] = RamIdxW'(rand_bits(RamIdxW));
      ram_write(idx_list[i], 2'(rand_bits(2)), 4'hF, rand_bits(32));
    end
    for (int i = 0; i < NrWords; i++) begin
      ram_write(idx_list[i], 2'(rand_bits(2)), 4'(rand_bits(4)), rand_bits(32));
    end
    for (int i = 0; i < NrWords; i++) begin
      ram_read(idx_list[i], 2'(rand_bits(2)));
    end
    // Read straight after write
    for (int i = 0; i < NrRaw; i++) begin
      sel = SelW'(rand_bits(SelW));
      ram_write(idx_list[sel], 2'(rand_bits(2)), 4'(rand_bits(4)), rand_bits(32));
      ram_read(idx_list[sel], 2'(rand_bits(2)));
    end

    drive(32'h0000_4000, 1'b0, 4'hF, '0, '0, 1'b1, 1'b1);
    drive(simple_system_pkg::TimerBase + 32'h10, 1'b0, 4'hF, '0, '0, 1'b1, 1'b1);

    drive(simple_system_pkg::TimerBase + simple_system_pkg::MtimeLo, 1'b0, 4'hF,
          '0, '0, 1'b0, 1'b0);
    idle(1);
    first_lo = host_rdata_o;
    idle(TimerGap - 2);
    drive(simple_system_pkg::TimerBase + simple_system_pkg::MtimeLo, 1'b0, 4'hF,
          '0, first_lo + 32'(TimerGap), 1'b0, 1'b1);
    target = first_lo + 32'(TimerGap) + 32'd20;
    drive(simple_system_pkg::TimerBase + simple_system_pkg::MtimecmpLo, 1'b1, 4'hF,
          target, '0, 1'b0, 1'b1);
    cmp_next[31:0] = target;
    drive(simple_system_pkg::TimerBase + simple_system_pkg::MtimecmpHi, 1'b1, 4'hF,
          '0, '0, 1'b0, 1'b1);
    cmp_next[63:32] = '0;
    idle(30);
    drive(simple_system_pkg::TimerBase + simple_system_pkg::MtimecmpHi, 1'b1, 4'hF,
          '1, '0, 1'b0, 1'b1);
    cmp_next[63:32] = '1;
    idle(3);

    data = rand_bits(32);
    drive(simple_system_pkg::SimCtrlBase + simple_system_pkg::SimCharOut, 1'b1, 4'h1,
          data, '0, 1'b0, 1'b1);
    nxt_char_valid = 1'b1;
    nxt_char       = data[7:0];
    drive(simple_system_pkg::SimCtrlBase + simple_system_pkg::SimCharOut, 1'b1, 4'hE,
          rand_bits(32), '0, 1'b0, 1'b1);
    drive(simple_system_pkg::SimCtrlBase + simple_system_pkg::SimHalt, 1'b1, 4'hF,
          32'h1, '0, 1'b0, 1'b1);
    nxt_halt = 1'b1;
    drive(simple_system_pkg::SimCtrlBase + simple_system_pkg::SimCharOut, 1'b0, 4'hF,
          '0, '0, 1'b0, 1'b1);
    idle(4);

    if (halt_o !== 1'b1) begin
      $display("halt_o was not set by the SimHalt write");
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/simple_system.sv */
// Memory-mapped system with one external bus host.
// The host port follows the request/grant/rvalid protocol. Grant is immediate.
// Devices are a byte-enabled RAM, a machine timer and simulation control.
// RamDepth is in 32-bit words and must be a power of two.
`timescale 1ns/1ns
`default_nettype none

module simple_system #(
  parameter int RamDepth = 1024
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_n_i,

  input  wire logic                                    host_req_i,
  input  wire logic [simple_system_pkg::AddrWidth-1:0] host_addr_i,
  input  wire logic                                    host_we_i,
  input  wire logic [simple_system_pkg::BeWidth-1:0]   host_be_i,
  input  wire logic [simple_system_pkg::DataWidth-1:0] host_wdata_i,
  output      logic                                    host_gnt_o,
  output      logic                                    host_rvalid_o,
  output      logic [simple_system_pkg::DataWidth-1:0] host_rdata_o,
  output      logic                                    host_err_o,

  output      logic                                    timer_irq_o,
  output      logic                                    char_valid_o,
  output      logic [7:0]                              char_o,
  output      logic                                    halt_o
);

  // One link per device, indexed by bus_device_e
  bus_dev_if dev_if [simple_system_pkg::NrDevices] ();

  system_bus u_bus (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .dev_o         (dev_if)
  );

  ram_1p #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dev     (dev_if[simple_system_pkg::Ram])
  );

  timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dev         (dev_if[simple_system_pkg::Timer]),
    .timer_irq_o (timer_irq_o)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .dev          (dev_if[simple_system_pkg::SimCtrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

endmodule

`default_nettype wire

/* verilog/sim_ctrl.sv */
// Simulation control device.
// A write to SimCharOut with be[0] set pulses char_valid_o for one cycle.
// Writing 1 to SimHalt sets halt_o until reset.
// Reads return 0 and never error.
`timescale 1ns/1ns
`default_nettype none

module sim_ctrl (
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  bus_dev_if.dev_mp       dev,
  output      logic       char_valid_o,
  output      logic [7:0] char_o,
  output      logic       halt_o
);

  localparam int AddrWidth = simple_system_pkg::AddrWidth;

  logic [AddrWidth-1:0] offset;
  logic                 wr_en;
  logic                 char_wr;
  logic                 halt_wr;

  logic                 rvalid_q;
  logic                 char_valid_q;
  logic [7:0]           char_q;
  logic                 halt_q;

  assign offset  = dev.addr & ~simple_system_pkg::SimCtrlMask & ~AddrWidth'(3);
  assign wr_en   = dev.req & dev.we;
  assign char_wr = wr_en & dev.be[0] & (offset == simple_system_pkg::SimCharOut);
  assign halt_wr = wr_en & dev.wdata[0] & (offset == simple_system_pkg::SimHalt);

  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_q <= dev.wdata[7:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q     <= 1'b0;
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      rvalid_q     <= dev.req;
      char_valid_q <= char_wr;
      // Sticky once set
      halt_q       <= halt_q | halt_wr;
    end
  end

  assign dev.rvalid   = rvalid_q;
  assign dev.rdata    = '0;
  assign dev.err      = 1'b0;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

  // Back-to-back strobes need back-to-back writes
  a_char_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (char_valid_o && $past(char_valid_o)) |-> $past(dev.req && dev.we));

endmodule

`default_nettype wire

/* timer/timer.sv */
// Machine timer with a 64-bit mtime and mtimecmp, seen as 32-bit halves.
// mtime counts every cycle; a write replaces the enabled bytes of one half.
// timer_irq_o is registered, one cycle behind the compare.
// Offsets above 0xC answer with err. Low address bits 1:0 are ignored.
`timescale 1ns/1ns
`default_nettype none

module timer (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  bus_dev_if.dev_mp dev,
  output      logic timer_irq_o
);

  localparam int AddrWidth = simple_system_pkg::AddrWidth;
  localparam int DataWidth = simple_system_pkg::DataWidth;
  localparam int BeWidth   = simple_system_pkg::BeWidth;

  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic [AddrWidth-1:0] offset;
  logic                 wr_en;

  logic [DataWidth-1:0] rd_data;
  logic                 rd_err;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;
  logic                 err_q;
  logic                 irq_q;

  // Merge the written bytes into one 32-bit half
  function automatic logic [DataWidth-1:0] merge_be(
    input logic [DataWidth-1:0] old_val,
    input logic [DataWidth-1:0] new_val,
    input logic [BeWidth-1:0]   be
  );
    logic [DataWidth-1:0] result;
    result = old_val;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign offset = dev.addr & ~simple_system_pkg::TimerMask & ~AddrWidth'(3);
  assign wr_en  = dev.req & dev.we;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
    end else if (wr_en && offset == simple_system_pkg::MtimeLo) begin
      mtime_q[31:0] <= merge_be(mtime_q[31:0], dev.wdata, dev.be);
    end else if (wr_en && offset == simple_system_pkg::MtimeHi) begin
      mtime_q[63:32] <= merge_be(mtime_q[63:32], dev.wdata, dev.be);
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // All ones keeps the interrupt off out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtimecmp_q <= '1;
    end else if (wr_en && offset == simple_system_pkg::MtimecmpLo) begin
      mtimecmp_q[31:0] <= merge_be(mtimecmp_q[31:0], dev.wdata, dev.be);
    end else if (wr_en && offset == simple_system_pkg::MtimecmpHi) begin
      mtimecmp_q[63:32] <= merge_be(mtimecmp_q[63:32], dev.wdata, dev.be);
    end
  end

  // Register read mux
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (offset)
      simple_system_pkg::MtimeLo:    rd_data = mtime_q[31:0];
      simple_system_pkg::MtimeHi:    rd_data = mtime_q[63:32];
      simple_system_pkg::MtimecmpLo: rd_data = mtimecmp_q[31:0];
      simple_system_pkg::MtimecmpHi: rd_data = mtimecmp_q[63:32];
      default:                       rd_err  = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (dev.req) begin
      rdata_q <= dev.we ? '0 : rd_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      rvalid_q <= dev.req;
      err_q    <= dev.req & rd_err;
      irq_q    <= mtime_q >= mtimecmp_q;
    end
  end

  assign dev.rvalid  = rvalid_q;
  assign dev.rdata   = rdata_q;
  assign dev.err     = err_q;
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* verilog/ram_1p.sv */
// Single-port word RAM behind the system bus.
// RamDepth must be a power of two. Addresses alias modulo RamDepth words.
// Writes update only the enabled bytes. Reads return one cycle later.
// Contents are undefined after power-up.
`timescale 1ns/1ns
`default_nettype none

module ram_1p #(
  parameter int RamDepth = 1024
) (
  input wire logic  clk_i,
  input wire logic  rst_n_i,
  bus_dev_if.dev_mp dev
);

  localparam int DataWidth = simple_system_pkg::DataWidth;
  localparam int BeWidth   = simple_system_pkg::BeWidth;
  localparam int IdxWidth  = $clog2(RamDepth);

  logic [DataWidth-1:0] mem [RamDepth];

  logic [IdxWidth-1:0]  word_idx;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_q;

  // Byte address bits 1:0 are dropped
  assign word_idx = dev.addr[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (dev.req && dev.we) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (dev.be[b]) begin
          mem[word_idx][8*b +: 8] <= dev.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data sampled before this cycle's write lands
  always_ff @(posedge clk_i) begin
    if (dev.req) begin
      rdata_q <= dev.we ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= dev.req;
    end
  end

  assign dev.rvalid = rvalid_q;
  assign dev.rdata  = rdata_q;
  assign dev.err    = 1'b0;

  a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dev.rvalid == $past(dev.req));

endmodule

`default_nettype wire

/* bus/system_bus.sv */
// Single-host bus with fixed address decode.
// Grant equals request, so the host is never stalled.
// Every response arrives one cycle after the grant. Misses answer with err.
// One request may be in flight while the next is granted.
`timescale 1ns/1ns
`default_nettype none

module system_bus (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_n_i,

  input  wire logic                                    host_req_i,
  input  wire logic [simple_system_pkg::AddrWidth-1:0] host_addr_i,
  input  wire logic                                    host_we_i,
  input  wire logic [simple_system_pkg::BeWidth-1:0]   host_be_i,
  input  wire logic [simple_system_pkg::DataWidth-1:0] host_wdata_i,
  output      logic                                    host_gnt_o,
  output      logic                                    host_rvalid_o,
  output      logic [simple_system_pkg::DataWidth-1:0] host_rdata_o,
  output      logic                                    host_err_o,

  bus_dev_if.bus_mp dev_o [simple_system_pkg::NrDevices]
);

  localparam int NrDev = simple_system_pkg::NrDevices;
  localparam int IdxW  = $clog2(NrDev);

  logic [simple_system_pkg::AddrWidth-1:0] dev_base [NrDev];
  logic [simple_system_pkg::AddrWidth-1:0] dev_mask [NrDev];

  logic [NrDev-1:0]                        dev_hit;
  logic [NrDev-1:0]                        dev_req;
  logic [IdxW-1:0]                         hit_idx;
  logic                                    miss;

  logic                                    dev_rvalid [NrDev];
  logic [simple_system_pkg::DataWidth-1:0] dev_rdata  [NrDev];
  logic                                    dev_err    [NrDev];

  // Response tracker
  logic            pending_q;
  logic            miss_q;
  logic [IdxW-1:0] sel_q;

  always_comb begin
    dev_base[simple_system_pkg::Ram]     = simple_system_pkg::RamBase;
    dev_mask[simple_system_pkg::Ram]     = simple_system_pkg::RamMask;
    dev_base[simple_system_pkg::SimCtrl] = simple_system_pkg::SimCtrlBase;
    dev_mask[simple_system_pkg::SimCtrl] = simple_system_pkg::SimCtrlMask;
    dev_base[simple_system_pkg::Timer]   = simple_system_pkg::TimerBase;
    dev_mask[simple_system_pkg::Timer]   = simple_system_pkg::TimerMask;
  end

  assign host_gnt_o = host_req_i;

  // Address decode
  always_comb begin
    hit_idx = '0;
    for (int i = 0; i < NrDev; i++) begin
      dev_hit[i] = (host_addr_i & dev_mask[i]) == dev_base[i];
      if (dev_hit[i]) begin
        hit_idx = IdxW'(i);
      end
    end
  end

  assign dev_req = {NrDev{host_req_i}} & dev_hit;
  assign miss    = host_req_i & ~(|dev_hit);

  // Only req is gated by the decode
  for (genvar i = 0; i < NrDev; i++) begin : g_dev
    assign dev_o[i].req   = dev_req[i];
    assign dev_o[i].addr  = host_addr_i;
    assign dev_o[i].we    = host_we_i;
    assign dev_o[i].be    = host_be_i;
    assign dev_o[i].wdata = host_wdata_i;

    assign dev_rvalid[i] = dev_o[i].rvalid;
    assign dev_rdata[i]  = dev_o[i].rdata;
    assign dev_err[i]    = dev_o[i].err;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      miss_q    <= 1'b0;
      sel_q     <= '0;
    end else begin
      pending_q <= |dev_req;
      miss_q    <= miss;
      sel_q     <= hit_idx;
    end
  end

  // Route the owed response back to the host
  always_comb begin
    host_rvalid_o = 1'b0;
    host_rdata_o  = '0;
    host_err_o    = 1'b0;
    if (miss_q) begin
      host_rvalid_o = 1'b1;
      host_err_o    = 1'b1;
    end else if (pending_q) begin
      host_rvalid_o = dev_rvalid[sel_q];
      host_rdata_o  = dev_rdata[sel_q];
      host_err_o    = dev_err[sel_q];
    end
  end

  // Windows must never overlap
  a_onehot_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(dev_req));

  // The tracked device keeps the one-cycle response promise
  a_dev_answers: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pending_q |-> dev_rvalid[sel_q]);

endmodule

`default_nettype wire

/* common/bus_dev_if.sv */
// Link between the system bus and one device.
// A device answers every req with rvalid exactly one cycle later.
// Writes get an rvalid too, with rdata 0.
`timescale 1ns/1ns
`default_nettype none

interface bus_dev_if;

  logic                                   req;
  logic [simple_system_pkg::AddrWidth-1:0] addr;
  logic                                   we;
  logic [simple_system_pkg::BeWidth-1:0]   be;
  logic [simple_system_pkg::DataWidth-1:0] wdata;

  logic                                   rvalid;
  logic [simple_system_pkg::DataWidth-1:0] rdata;
  logic                                   err;

  // Bus drives the request, the device answers
  modport bus_mp (
    output req, addr, we, be, wdata,
    input  rvalid, rdata, err
  );

  modport dev_mp (
    input  req, addr, we, be, wdata,
    output rvalid, rdata, err
  );

endinterface

`default_nettype wire

/* common/simple_system_pkg.sv */
// Shared definitions for the simple system RTL.
// Device windows must not overlap. The bus relies on at most one hit.
// Masks keep the address bits that select a window. Offsets are what they clear.
// Register offsets are word aligned and are relative to the window base.
`default_nettype none

package simple_system_pkg;

  // Device index into the bus interface array
  typedef enum int {
    Ram,
    SimCtrl,
    Timer
  } bus_device_e;

  localparam int NrDevices = 3;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  // Address map
  localparam logic [AddrWidth-1:0] RamBase     = 32'h0010_0000;
  localparam logic [AddrWidth-1:0] RamMask     = ~32'h000F_FFFF;  // 1 MB
  localparam logic [AddrWidth-1:0] SimCtrlBase = 32'h0002_0000;
  localparam logic [AddrWidth-1:0] SimCtrlMask = ~32'h0000_03FF;  // 1 kB
  localparam logic [AddrWidth-1:0] TimerBase   = 32'h0003_0000;
  localparam logic [AddrWidth-1:0] TimerMask   = ~32'h0000_03FF;  // 1 kB

  // Timer registers
  localparam logic [AddrWidth-1:0] MtimeLo    = 32'h0;
  localparam logic [AddrWidth-1:0] MtimeHi    = 32'h4;
  localparam logic [AddrWidth-1:0] MtimecmpLo = 32'h8;
  localparam logic [AddrWidth-1:0] MtimecmpHi = 32'hC;

  // Simulation control registers
  localparam logic [AddrWidth-1:0] SimCharOut = 32'h0;
  localparam logic [AddrWidth-1:0] SimHalt    = 32'h8;

endpackage

`default_nettype wire
